// File: dv/block_plotter_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "plot_params.svh"

module tb_block_plotter;
	import plot_pkg::*;

	localparam int W = `PLOT_SCREEN_W;
	localparam int H = `PLOT_SCREEN_H;
	localparam int SIDE = `PLOT_BLOCK_SIDE;
	localparam int NPIX = W * H;	// Writes per clear
	localparam int LIMIT_CYC = 55 * 40 + 5 * 19300 + 5 * 19300 + 200;	// Blocks, clears, sweeps

	logic clk, reset, go, plot, black, write_en, busy;
	coord_t position_in, rd_x, rd_y, pix_x, pix_y;
	palette_t colour_in;
	colour_t rd_colour, pix_colour;
	colour_t model [W][H];	// Expected frame contents
	coord_t cur_x, cur_y;	// Last loaded values
	palette_t cur_pal;
	logic [31:0] lfsr = 32'd98;
	int errors = 0, checks = 0, tests = 0, err_mark = 0;
	int write_count = 0, exp_writes = 0;

	block_plotter DUT (.clk(clk), .reset(reset), .go(go), .plot(plot), .black(black),
		.position_in(position_in), .colour_in(colour_in), .rd_x(rd_x), .rd_y(rd_y),
		.rd_colour(rd_colour), .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
		.write_en(write_en), .busy(busy));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial begin
		#(LIMIT_CYC * 4);
		$display("Run stopped by watchdog before the tests completed");
		$display("Errors found");
		$finish;
	end

	always @(posedge clk)
		if (!reset && write_en)
			write_count++;	// Every write the DUT makes

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];	// One step per bit
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic colour_t expand(input palette_t p);
		return {p[2] ? 8'hff : 8'h00, p[1] ? 8'hff : 8'h00, p[0] ? 8'hff : 8'h00};
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			$display("%s at %0t", what, $time);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
		err_mark = errors;
	endtask

	task automatic quiet();
		go = 1'b0;
		plot = 1'b0;
		black = 1'b0;
	endtask

	task automatic drive_noise();
		go = rand_bits(1);	// Should all be ignored while busy
		plot = rand_bits(1);
		black = rand_bits(1);
		position_in = rand_bits(9);
		colour_in = rand_bits(3);
	endtask

	task automatic press_go(input coord_t pos, input palette_t pal);
		@(negedge clk);
		go = 1'b1;
		position_in = pos;
		colour_in = pal;
		@(posedge clk);
		@(negedge clk);
		go = 1'b0;
		@(posedge clk);	// Release seen
	endtask

	task automatic load_xy(input coord_t x, input coord_t y, input palette_t pal);
		press_go(x, 3'd0);
		press_go(y, pal);
		cur_x = x;
		cur_y = y;
		cur_pal = pal;
	endtask

	task automatic plot_block(input bit noise);
		logic [9:0] ex, ey;
		@(negedge clk);
		plot = 1'b1;
		@(posedge clk);
		check_true(!write_en, "write_en high on the plot edge");
		for (int k = 0; k < SIDE * SIDE; k++) begin
			@(negedge clk);
			if (noise)
				drive_noise();
			else
				quiet();
			@(posedge clk);
			ex = cur_x + k % SIDE;	// Column within block
			ey = cur_y + k / SIDE;
			check_true(write_en && busy, "write_en or busy low inside the block burst");
			check_val("pix_x", ex, pix_x);
			check_val("pix_y", ey, pix_y);
			check_val("pix_colour", expand(cur_pal), pix_colour);
			if (ex < W && ey < H)
				model[ex][ey] = expand(cur_pal);	// Clipped in memory only
		end
		@(negedge clk);
		quiet();
		@(posedge clk);
		check_true(!write_en && !busy, "block burst ran past 16 cycles");
		exp_writes += SIDE * SIDE;
	endtask

	task automatic do_clear(input bit noise, input bit with_plot);
		int n;
		bit done;
		n = 0;
		done = 0;
		@(negedge clk);
		black = 1'b1;
		plot = with_plot;	// Black should win
		@(posedge clk);
		while (!done && n < NPIX + 100) begin
			@(negedge clk);
			if (noise && n < NPIX)
				drive_noise();
			else
				quiet();
			@(posedge clk);
			check_true(busy === write_en, "busy differs from write_en during clear");
			if (write_en) begin
				check_val("pix_x", n % W, pix_x);	// Raster order
				check_val("pix_y", n / W, pix_y);
				check_val("pix_colour", 0, pix_colour);
				n++;
			end else
				done = 1;
		end
		check_true(n == NPIX, "clear did not last 19200 write cycles");
		foreach (model[i, j])
			model[i][j] = '0;
		exp_writes += NPIX;
	endtask

	task automatic read_back();
		for (int i = 0; i <= NPIX; i++) begin
			@(negedge clk);
			if (i < NPIX) begin
				rd_x = i % W;
				rd_y = i / W;
			end
			@(posedge clk);
			if (i > 0)
				check_val("rd_colour", model[(i - 1) % W][(i - 1) / W], rd_colour);	// One cycle late
		end
	endtask

	initial begin
		reset = 1'b1;
		quiet();
		position_in = '0;
		colour_in = '0;
		rd_x = '0;
		rd_y = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		check_true(!write_en && !busy, "write_en or busy high after reset");
		do_clear(0, 0);
		read_back();
		end_test("reset and initial clear");

		load_xy(rand_bits(8) % 157, rand_bits(7) % 117, rand_bits(3));
		plot_block(0);
		end_test("single block stream");

		repeat (40) begin
			load_xy(rand_bits(8) % 157, rand_bits(7) % 117, rand_bits(3));
			plot_block(0);
		end
		read_back();
		end_test("forty random blocks");

		repeat (8) begin
			load_xy(150 + rand_bits(6), 110 + rand_bits(6), rand_bits(3));	// Past both edges
			plot_block(0);
		end
		read_back();
		end_test("edge clipping");

		do_clear(0, 0);
		read_back();
		press_go(rand_bits(8) % 157, 3'd0);
		cur_x = position_in;
		do_clear(0, 0);	// Cleared mid-load so loading resumes in wait_y
		press_go(rand_bits(7) % 117, rand_bits(3));
		cur_y = position_in;
		cur_pal = colour_in;
		plot_block(0);
		end_test("clear and resumed loading");

		load_xy(rand_bits(8) % 157, rand_bits(7) % 117, rand_bits(3));
		repeat (4)
			plot_block(1);
		do_clear(1, 0);
		do_clear(0, 1);	// Black and plot together
		plot_block(0);
		read_back();
		@(negedge clk);
		check_val("write_count", exp_writes, write_count);
		end_test("inputs ignored while busy");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/block_plotter.sv
`timescale 1ns/1ns
`default_nettype none

module block_plotter (
	input  logic clk,
	input  logic reset,
	input  logic go,	// Load strobe, x then y
	input  logic plot,	// Draw the block
	input  logic black,	// Clear the screen
	input  plot_pkg::coord_t position_in,
	input  plot_pkg::palette_t colour_in,
	input  plot_pkg::coord_t rd_x,	// Scan-out read port
	input  plot_pkg::coord_t rd_y,
	output plot_pkg::colour_t rd_colour,
	output plot_pkg::coord_t pix_x,	// Pixel write bus, also to memory
	output plot_pkg::coord_t pix_y,
	output plot_pkg::colour_t pix_colour,
	output logic write_en,
	output logic busy
);

	// Strobes and last flags between control and datapath
	draw_ctrl_if ctrl_if (
		.clk(clk)
	);

	plot_fsm u_fsm (
		.clk     (clk),
		.reset   (reset),
		.go      (go),
		.plot    (plot),
		.black   (black),
		.ctrl    (ctrl_if.fsm),
		.write_en(write_en),
		.busy    (busy)
	);

	plot_datapath u_datapath (
		.clk        (clk),
		.reset      (reset),
		.position_in(position_in),
		.colour_in  (colour_in),
		.ctrl       (ctrl_if.datapath),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_colour (pix_colour)
	);

	// Stands in for the VGA adapter memory
	frame_buffer u_frame_buffer (
		.clk      (clk),
		.write_en (write_en),
		.wr_x     (pix_x),
		.wr_y     (pix_y),
		.wr_colour(pix_colour),
		.rd_x     (rd_x),
		.rd_y     (rd_y),
		.rd_colour(rd_colour)
	);

endmodule

`default_nettype wire

// File: src/draw_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface draw_ctrl_if (
	input logic clk
);

	logic load_x;	// Take x from position_in
	logic load_y;	// Take y and palette
	logic start_block;	// Zero the block counter
	logic step_block;	// Advance one block pixel
	logic start_clear;	// Zero the raster counter
	logic step_clear;	// Advance one raster pixel
	logic draw_black;	// Raster address with colour 0
	logic block_last;	// Block counter on final pixel
	logic clear_last;	// Raster counter on final pixel

	modport fsm (
		output load_x, load_y, start_block, step_block,
		output start_clear, step_clear, draw_black,
		input  block_last, clear_last
	);

	modport datapath (
		input  load_x, load_y, start_block, step_block,
		input  start_clear, step_clear, draw_black,
		output block_last, clear_last
	);

	// Draw and clear never launched on the same edge
	a_start_excl: assert property (@(posedge clk) !(start_block && start_clear))
		else $error("draw_ctrl_if: block and clear started together");

endinterface

`default_nettype wire

// File: src/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "plot_params.svh"

module frame_buffer (
	input  logic clk,
	input  logic write_en,
	input  plot_pkg::coord_t wr_x,
	input  plot_pkg::coord_t wr_y,
	input  plot_pkg::colour_t wr_colour,
	input  plot_pkg::coord_t rd_x,
	input  plot_pkg::coord_t rd_y,
	output plot_pkg::colour_t rd_colour
);
	import plot_pkg::*;

	localparam int DEPTH = `PLOT_SCREEN_W * `PLOT_SCREEN_H;	// One word per pixel
	localparam int AW    = $clog2(DEPTH);
	localparam coord_t MAX_X = coord_t'(`PLOT_SCREEN_W);
	localparam coord_t MAX_Y = coord_t'(`PLOT_SCREEN_H);

	colour_t mem [DEPTH];	// Row-major pixel store
	logic wr_in;	// Write address on screen
	logic rd_in;	// Read address on screen
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	assign wr_in   = (wr_x < MAX_X) && (wr_y < MAX_Y);
	assign rd_in   = (rd_x < MAX_X) && (rd_y < MAX_Y);
	assign wr_addr = AW'(wr_y * `PLOT_SCREEN_W + wr_x);	// Row times width plus column
	assign rd_addr = AW'(rd_y * `PLOT_SCREEN_W + rd_x);

	always_ff @(posedge clk) begin
		if (write_en && wr_in)
			mem[wr_addr] <= wr_colour;	// Off-screen writes fall away
		rd_colour <= rd_in ? mem[rd_addr] : '0;	// One cycle read latency
	end

	// Bad data from the datapath would poison the frame
	a_wr_known: assert property (@(posedge clk)
		write_en |-> !$isunknown({wr_x, wr_y, wr_colour}))
		else $error("frame_buffer: unknown bits on write port");

endmodule

`default_nettype wire

// File: src/plot_datapath.sv
`timescale 1ns/1ns
`default_nettype none
`include "plot_params.svh"

module plot_datapath (
	input  logic clk,
	input  logic reset,
	input  plot_pkg::coord_t position_in,
	input  plot_pkg::palette_t colour_in,
	draw_ctrl_if.datapath ctrl,
	output plot_pkg::coord_t pix_x,
	output plot_pkg::coord_t pix_y,
	output plot_pkg::colour_t pix_colour
);
	import plot_pkg::*;

	localparam int BLK_N  = `PLOT_BLOCK_SIDE * `PLOT_BLOCK_SIDE;
	localparam int BLK_W  = $clog2(BLK_N);	// Block counter width
	localparam int SIDE_W = $clog2(`PLOT_BLOCK_SIDE);	// Offset bits per axis
	localparam int CW     = $bits(coord_t);
	localparam int CH_W   = `PLOT_COLOUR_BITS / 3;	// One channel
	localparam coord_t LAST_COL = coord_t'(`PLOT_SCREEN_W - 1);
	localparam coord_t LAST_ROW = coord_t'(`PLOT_SCREEN_H - 1);
	localparam logic [BLK_W-1:0] LAST_BLK = BLK_W'(BLK_N - 1);

	coord_t x_q;	// Loaded block origin
	coord_t y_q;
	palette_t pal_q;	// Loaded colour index
	logic [BLK_W-1:0] blk_cnt;	// Low bits column, high bits row
	coord_t col_q;	// Raster column for clear
	coord_t row_q;	// Raster row for clear
	logic [CW:0] sum_x;	// One spare bit to catch wrap
	logic [CW:0] sum_y;
	colour_t pal_colour;

	always_ff @(posedge clk) begin
		if (reset) begin
			x_q   <= '0;
			y_q   <= '0;
			pal_q <= '0;
		end else begin
			if (ctrl.load_x)
				x_q <= position_in;
			if (ctrl.load_y) begin
				y_q   <= position_in;
				pal_q <= colour_in;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || ctrl.start_block)
			blk_cnt <= '0;
		else if (ctrl.step_block)
			blk_cnt <= blk_cnt + 1'b1;	// Wraps to 0 after last pixel
	end

	always_ff @(posedge clk) begin
		if (reset || ctrl.start_clear) begin
			col_q <= '0;
			row_q <= '0;
		end else if (ctrl.step_clear) begin
			if (col_q == LAST_COL) begin
				col_q <= '0;
				row_q <= row_q + 1'b1;	// Next raster line
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	assign ctrl.block_last = (blk_cnt == LAST_BLK);
	assign ctrl.clear_last = (col_q == LAST_COL) && (row_q == LAST_ROW);

	// Origin plus offset inside the block
	assign sum_x = {1'b0, x_q} + {{(CW + 1 - SIDE_W){1'b0}}, blk_cnt[SIDE_W-1:0]};
	assign sum_y = {1'b0, y_q} + {{(CW + 1 - SIDE_W){1'b0}}, blk_cnt[BLK_W-1:SIDE_W]};

	// Each index bit fills a whole channel
	assign pal_colour = {{CH_W{pal_q[2]}}, {CH_W{pal_q[1]}}, {CH_W{pal_q[0]}}};

	always_comb begin
		if (ctrl.draw_black) begin
			pix_x      = col_q;
			pix_y      = row_q;
			pix_colour = '0;	// Clear writes black
		end else begin
			// Overflow pinned off screen rather than wrapping to column 0
			pix_x      = sum_x[CW] ? '1 : sum_x[CW-1:0];
			pix_y      = sum_y[CW] ? '1 : sum_y[CW-1:0];
			pix_colour = pal_colour;
		end
	end

	// FSM only steps one counter per cycle
	a_step_excl: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.step_block && ctrl.step_clear))
		else $error("plot_datapath: block and clear counters stepped together");

endmodule

`default_nettype wire

// File: src/plot_fsm.sv
`timescale 1ns/1ns
`default_nettype none
`include "plot_params.svh"

module plot_fsm (
	input  logic clk,
	input  logic reset,
	input  logic go,
	input  logic plot,
	input  logic black,
	draw_ctrl_if.fsm ctrl,
	output logic write_en,
	output logic busy
);
	import plot_pkg::*;

	localparam int BLK_N = `PLOT_BLOCK_SIDE * `PLOT_BLOCK_SIDE;	// Writes per block

	plot_state_t state;	// Current state
	plot_state_t state_nx;	// Next state
	plot_state_t ret_q;	// State to resume after a clear
	logic writing;	// In a pixel write state

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= wait_x;
			ret_q <= wait_x;
		end else begin
			state <= state_nx;
			if (ctrl.start_clear)
				ret_q <= state;	// Remember where loading stood
		end
	end

	always_comb begin
		state_nx         = state;
		ctrl.load_x      = 1'b0;
		ctrl.load_y      = 1'b0;
		ctrl.start_block = 1'b0;
		ctrl.step_block  = 1'b0;
		ctrl.start_clear = 1'b0;
		ctrl.step_clear  = 1'b0;
		ctrl.draw_black  = 1'b0;
		if (!writing && black) begin
			// Black beats go and plot
			ctrl.start_clear = 1'b1;
			state_nx         = clear;
		end else begin
			case (state)
				wait_x: begin
					if (go) begin
						ctrl.load_x = 1'b1;
						state_nx    = hold_x;
					end
				end
				hold_x: begin
					if (!go)
						state_nx = wait_y;	// Release seen
				end
				wait_y: begin
					if (go) begin
						ctrl.load_y = 1'b1;	// Colour rides with y
						state_nx    = hold_y;
					end
				end
				hold_y: begin
					if (!go)
						state_nx = idle;
				end
				idle: begin
					if (plot) begin
						ctrl.start_block = 1'b1;
						state_nx         = draw;
					end else if (go) begin
						ctrl.load_x = 1'b1;	// New coordinate pair
						state_nx    = hold_x;
					end
				end
				draw: begin
					ctrl.step_block = 1'b1;
					if (ctrl.block_last)
						state_nx = idle;	// Last pixel this cycle
				end
				clear: begin
					ctrl.step_clear = 1'b1;
					ctrl.draw_black = 1'b1;
					if (ctrl.clear_last)
						state_nx = ret_q;
				end
				default: state_nx = wait_x;
			endcase
		end
	end

	assign writing  = (state == draw) || (state == clear);
	assign write_en = writing;
	assign busy     = writing;	// Same cycles as the writes

	// One plot gives one unbroken burst of block writes
	a_draw_burst: assert property (@(posedge clk) disable iff (reset)
		$rose(state == draw) |-> write_en [*BLK_N] ##1 !write_en)
		else $error("plot_fsm: block burst length wrong");

	// Coordinates stay frozen while pixels go out
	a_no_load_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !(ctrl.load_x || ctrl.load_y))
		else $error("plot_fsm: load strobe while busy");

endmodule

`default_nettype wire

// File: src/plot_params.svh
`ifndef PLOT_PARAMS_SVH
`define PLOT_PARAMS_SVH

// Visible area of the display
`define PLOT_SCREEN_W 160	// Pixels per row
`define PLOT_SCREEN_H 120	// Rows per frame

// Drawn block side must stay a power of two
`define PLOT_BLOCK_SIDE 4

// Pixel colour of three equal channels
`define PLOT_COLOUR_BITS 24

`endif

// File: src/plot_pkg.sv
`default_nettype none
`include "plot_params.svh"

package plot_pkg;

	typedef logic [8:0] coord_t;	// Unsigned pixel x or y
	typedef logic [`PLOT_COLOUR_BITS-1:0] colour_t;	// R in top byte, then G, then B
	typedef logic [2:0] palette_t;	// Bit 2 red, bit 1 green, bit 0 blue

	// Controller states
	typedef enum logic [2:0] {
		wait_x,	// Waiting for go with x on the switches
		hold_x,	// x taken, waiting for go release
		wait_y,	// Waiting for go with y and colour
		hold_y,	// y taken, waiting for go release
		idle,	// Coordinates loaded, ready to plot
		draw,	// Writing the block pixels
		clear	// Writing black over the screen
	} plot_state_t;

endpackage

`default_nettype wire

// File: verilog.f
+incdir+src
src/plot_pkg.sv
src/draw_ctrl_if.sv
src/plot_fsm.sv
src/plot_datapath.sv
src/frame_buffer.sv
src/block_plotter.sv
dv/block_plotter_tb.sv
